//--- Bender.yml
package:
  name: core6809

sources:
  - include_dirs:
      - .
    files:
      - core6809_pkg.sv
      - core6809_wb_if.sv
      - fetch_sequencer.sv
      - instr_decode.sv
      - alu_execute.sv
      - accum_regs.sv
      - core6809.sv
  - target: test
    files:
      - tb_core6809.sv

//--- accum_regs.sv
// Register stage for the 6809 front end
// Accumulators A and B plus the condition-code register,
// loaded from the write-back bundle
`timescale 1ns/1ps
`include "core6809_consts.svh"

module accum_regs import core6809_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_b,
  core6809_wb_if.rcv              wb,
  output logic [`CORE_DATA_W-1:0] a_val,
  output logic [`CORE_DATA_W-1:0] b_val,
  output logic [`CORE_DATA_W-1:0] cc_val
);

  // Any accumulator write also updates the flags
  logic wr_any;

  assign wr_any = wb.wr_a || wb.wr_b;

  // ----------------------------------------
  // Architectural registers
  // ----------------------------------------

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a_val  <= '0;
      b_val  <= '0;
      cc_val <= `CORE_CC_RESET;
    end else begin
      if (wb.wr_a) begin
        a_val <= wb.result;
      end
      if (wb.wr_b) begin
        b_val <= wb.result;
      end
      // Only N, Z, V and C move
      // E, F, H and I keep their value
      if (wr_any) begin
        {cc_val[CC_N], cc_val[CC_Z], cc_val[CC_V], cc_val[CC_C]} <= wb.flags;
      end
    end
  end

endmodule

//--- alu_execute.sv
// Execute stage for the 6809 front end
// Operand select, CLR/INC/DEC/COM/NEG result and N/Z/V/C flags,
// write-back strobes onto the register bundle
`timescale 1ns/1ps
`include "core6809_consts.svh"

module alu_execute import core6809_pkg::*; (
  input  alu_op_t                 op,
  input  acc_sel_t                acc,
  input  logic [`CORE_DATA_W-1:0] a_val,
  input  logic [`CORE_DATA_W-1:0] b_val,
  input  logic [`CORE_DATA_W-1:0] cc_val,
  core6809_wb_if.drv              wb
);

  // Overflow boundaries for INC and DEC/NEG
  localparam logic [`CORE_DATA_W-1:0] MAX_POS = {1'b0, {(`CORE_DATA_W-1){1'b1}}};
  localparam logic [`CORE_DATA_W-1:0] MIN_NEG = {1'b1, {(`CORE_DATA_W-1){1'b0}}};

  logic [`CORE_DATA_W-1:0] operand;
  logic [`CORE_DATA_W-1:0] result;
  logic                    flag_n;
  logic                    flag_z;
  logic                    flag_v;
  logic                    flag_c;
  logic                    op_live;

  // ----------------------------------------
  // Result and V/C
  // ----------------------------------------

  assign operand = (acc == ACC_B) ? b_val : a_val;

  always_comb begin
    // INC and DEC keep the carry
    result = operand;
    flag_v = 1'b0;
    flag_c = cc_val[CC_C];
    case (op)
      OP_CLR: begin
        result = '0;
        flag_c = 1'b0;
      end
      OP_INC: begin
        result = operand + 1'b1;
        flag_v = (operand == MAX_POS);
      end
      OP_DEC: begin
        result = operand - 1'b1;
        flag_v = (operand == MIN_NEG);
      end
      OP_COM: begin
        result = ~operand;
        flag_c = 1'b1;
      end
      OP_NEG: begin
        // Two's complement, borrow out unless zero
        result = '0 - operand;
        flag_v = (operand == MIN_NEG);
        flag_c = |operand;
      end
      default: result = operand;
    endcase
  end

  // N and Z straight from the result
  assign flag_n = result[`CORE_DATA_W-1];
  assign flag_z = (result == '0);

  // ----------------------------------------
  // Write-back
  // ----------------------------------------

  assign op_live   = (op != OP_NONE);
  assign wb.wr_a   = op_live && (acc == ACC_A);
  assign wb.wr_b   = op_live && (acc == ACC_B);
  assign wb.result = result;
  assign wb.flags  = {flag_n, flag_z, flag_v, flag_c};

endmodule

//--- core6809.f
+incdir+.
core6809_pkg.sv
core6809_wb_if.sv
fetch_sequencer.sv
instr_decode.sv
alu_execute.sv
accum_regs.sv
core6809.sv
tb_core6809.sv

//--- core6809.sv
// Top level of the 6809 front end
// Fetch, decode, execute and register stages joined by plain wires
// and the write-back interface
`timescale 1ns/1ps
`include "core6809_consts.svh"

module core6809 import core6809_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_b,
  input  logic                    halt_b,
  input  logic [`CORE_DATA_W-1:0] data_in,
  output logic [`CORE_ADDR_W-1:0] addr,
  output logic [`CORE_DATA_W-1:0] acc_a,
  output logic [`CORE_DATA_W-1:0] acc_b,
  output logic [`CORE_DATA_W-1:0] cc
);

  // Fetch to decode
  logic [`CORE_DATA_W-1:0] ir;
  logic                    ir_valid;

  // Decode to execute
  alu_op_t                 op;
  acc_sel_t                acc;

  // Register state fed back into execute
  logic [`CORE_DATA_W-1:0] a_val;
  logic [`CORE_DATA_W-1:0] b_val;
  logic [`CORE_DATA_W-1:0] cc_val;

  // Execute to register stage
  core6809_wb_if wb_bus ();

  // ----------------------------------------
  // Stages
  // ----------------------------------------

  fetch_sequencer u_fetch (
    .clk      (clk),
    .reset_b  (reset_b),
    .halt_b   (halt_b),
    .data_in  (data_in),
    .addr     (addr),
    .ir       (ir),
    .ir_valid (ir_valid)
  );

  instr_decode u_decode (
    .ir       (ir),
    .ir_valid (ir_valid),
    .op       (op),
    .acc      (acc)
  );

  alu_execute u_execute (
    .op     (op),
    .acc    (acc),
    .a_val  (a_val),
    .b_val  (b_val),
    .cc_val (cc_val),
    .wb     (wb_bus.drv)
  );

  accum_regs u_regs (
    .clk     (clk),
    .reset_b (reset_b),
    .wb      (wb_bus.rcv),
    .a_val   (a_val),
    .b_val   (b_val),
    .cc_val  (cc_val)
  );

  // Status out
  assign acc_a = a_val;
  assign acc_b = b_val;
  assign cc    = cc_val;

endmodule

//--- core6809_consts.svh
// Width and reset constants for the 6809 front end
// Data and address widths, reset vector location, CC reset value
`ifndef CORE6809_CONSTS_SVH
`define CORE6809_CONSTS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

// Byte-wide data bus
`define CORE_DATA_W 8

// 64K address space
`define CORE_ADDR_W 16

// ----------------------------------------
// Reset values
// ----------------------------------------

// Vector high byte here, low byte at the next address up
`define CORE_RST_VEC_HI 16'hFFFE

// All CC bits set out of reset, interrupts masked
`define CORE_CC_RESET 8'hFF

`endif

//--- core6809_pkg.sv
// Shared types for the 6809 front end
// Fetch states, ALU operations, accumulator select, CC bit positions
package core6809_pkg;

  // ----------------------------------------
  // Fetch sequencer states
  // ----------------------------------------

  // Reset vector is fetched big-endian, high byte first
  typedef enum logic [1:0] {
    ST_RESET,
    ST_VEC_HI,
    ST_VEC_LO,
    ST_RUN
  } fetch_state_t;

  // ----------------------------------------
  // Execute controls
  // ----------------------------------------

  // Inherent-mode accumulator operations
  typedef enum logic [2:0] {
    OP_NONE,
    OP_CLR,
    OP_INC,
    OP_DEC,
    OP_COM,
    OP_NEG
  } alu_op_t;

  // Target accumulator
  typedef enum logic {
    ACC_A,
    ACC_B
  } acc_sel_t;

  // Condition-code bit positions
  localparam int unsigned CC_E = 7;  // Entire state saved
  localparam int unsigned CC_F = 6;  // FIRQ mask
  localparam int unsigned CC_H = 5;  // Half carry
  localparam int unsigned CC_I = 4;  // IRQ mask
  localparam int unsigned CC_N = 3;  // Negative
  localparam int unsigned CC_Z = 2;  // Zero
  localparam int unsigned CC_V = 1;  // Overflow
  localparam int unsigned CC_C = 0;  // Carry

endpackage

//--- core6809_wb_if.sv
// Write-back bundle from execute to the register stage
// Write strobes, result byte and N/Z/V/C flag nibble
`timescale 1ns/1ps
`include "core6809_consts.svh"

interface core6809_wb_if;

  // Per-accumulator write strobes, at most one high
  logic                    wr_a;
  logic                    wr_b;

  // Result byte for the selected accumulator
  logic [`CORE_DATA_W-1:0] result;

  // Packed as {N, Z, V, C}
  logic [3:0]              flags;

  // Execute side
  modport drv (output wr_a, output wr_b, output result, output flags);

  // Register side
  modport rcv (input wr_a, input wr_b, input result, input flags);

endinterface

//--- fetch_sequencer.sv
// Fetch sequencer for the 6809 front end
// Reset vector fetch FSM, program counter, address register,
// instruction register and halt control
`timescale 1ns/1ps
`include "core6809_consts.svh"

module fetch_sequencer import core6809_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_b,
  input  logic                    halt_b,
  input  logic [`CORE_DATA_W-1:0] data_in,
  output logic [`CORE_ADDR_W-1:0] addr,
  output logic [`CORE_DATA_W-1:0] ir,
  output logic                    ir_valid
);

  fetch_state_t            state;
  fetch_state_t            state_nxt;

  // Address of the byte after the one on addr
  logic [`CORE_ADDR_W-1:0] pc;

  // Full vector once the low byte is on the bus
  logic [`CORE_ADDR_W-1:0] vector;

  // Running and not held off by halt
  logic                    run_go;

  assign run_go = (state == ST_RUN) && halt_b;
  assign vector = {pc[`CORE_ADDR_W-1:`CORE_DATA_W], data_in};

  // ----------------------------------------
  // State machine
  // ----------------------------------------

  // Linear walk through the vector fetch, then stay in run
  always_comb begin
    case (state)
      ST_RESET:  state_nxt = ST_VEC_HI;
      ST_VEC_HI: state_nxt = ST_VEC_LO;
      ST_VEC_LO: state_nxt = ST_RUN;
      default:   state_nxt = ST_RUN;
    endcase
  end

  // Sequencer state, bus address and valid flag
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state    <= ST_RESET;
      addr     <= `CORE_RST_VEC_HI;
      ir_valid <= 1'b0;
    end else begin
      state    <= state_nxt;
      // Valid only for bytes actually captured
      ir_valid <= run_go;
      case (state)
        // Step to the low vector byte
        ST_VEC_HI: addr <= `CORE_RST_VEC_HI + 1'b1;
        // Jump to the assembled vector
        ST_VEC_LO: addr <= vector;
        // One byte per cycle, frozen while halted
        ST_RUN: begin
          if (halt_b) begin
            addr <= pc;
          end
        end
        // Hold on the high vector byte
        default:   addr <= `CORE_RST_VEC_HI;
      endcase
    end
  end

  // ----------------------------------------
  // Program counter and instruction register
  // ----------------------------------------

  // Vector assembled big-endian into pc
  always_ff @(posedge clk) begin
    case (state)
      ST_VEC_HI: pc[`CORE_ADDR_W-1:`CORE_DATA_W] <= data_in;
      ST_VEC_LO: pc <= vector + 1'b1;
      ST_RUN: begin
        if (halt_b) begin
          pc <= pc + 1'b1;
        end
      end
      default:   pc <= pc;
    endcase
  end

  // Opcode at addr captured at the end of its cycle
  always_ff @(posedge clk) begin
    if (run_go) begin
      ir <= data_in;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // In run, pc stays one ahead of the bus address through halts
  a_pc_lead: assert property (@(posedge clk) disable iff (!reset_b)
    (state == ST_RUN) |-> (pc == addr + 1'b1))
    else $error("FAIL pc out of step with addr, pc=%h addr=%h", pc, addr);

endmodule

//--- instr_decode.sv
// Instruction decode for the 6809 front end
// Maps the opcode byte to an ALU operation and target accumulator
`timescale 1ns/1ps
`include "core6809_consts.svh"

module instr_decode import core6809_pkg::*; (
  input  logic [`CORE_DATA_W-1:0] ir,
  input  logic                    ir_valid,
  output alu_op_t                 op,
  output acc_sel_t                acc
);

  // ----------------------------------------
  // Inherent accumulator opcode fields
  // ----------------------------------------

  // Upper nibble picks the accumulator
  localparam logic [3:0] GRP_ACC_A = 4'h4;
  localparam logic [3:0] GRP_ACC_B = 4'h5;

  // Lower nibble picks the operation
  localparam logic [3:0] FN_NEG = 4'h0;
  localparam logic [3:0] FN_COM = 4'h3;
  localparam logic [3:0] FN_DEC = 4'hA;
  localparam logic [3:0] FN_INC = 4'hC;
  localparam logic [3:0] FN_CLR = 4'hF;

  logic [3:0] grp;
  logic [3:0] fn;
  logic       grp_hit;
  alu_op_t    fn_op;

  assign grp = ir[7:4];
  assign fn  = ir[3:0];

  // Only the 4x and 5x rows hold kept instructions
  assign grp_hit = (grp == GRP_ACC_A) || (grp == GRP_ACC_B);

  // Operation from the low nibble alone
  always_comb begin
    case (fn)
      FN_NEG:  fn_op = OP_NEG;
      FN_COM:  fn_op = OP_COM;
      FN_DEC:  fn_op = OP_DEC;
      FN_INC:  fn_op = OP_INC;
      FN_CLR:  fn_op = OP_CLR;
      default: fn_op = OP_NONE;
    endcase
  end

  // NOP and every unlisted opcode fall out as OP_NONE
  assign op  = (ir_valid && grp_hit) ? fn_op : OP_NONE;
  assign acc = (grp == GRP_ACC_B) ? ACC_B : ACC_A;

endmodule

//--- tb_core6809.sv
// Testbench for the 6809 front end
// Memory model with reset vector and program, reference model of the
// accumulator pipeline, random halt stimulus, checking assertions
`timescale 1ns/1ps

module tb_core6809;

  // Kept inherent opcodes and NOP
  localparam logic [7:0] OPC_NEGA = 8'h40;
  localparam logic [7:0] OPC_COMA = 8'h43;
  localparam logic [7:0] OPC_DECA = 8'h4A;
  localparam logic [7:0] OPC_INCA = 8'h4C;
  localparam logic [7:0] OPC_CLRA = 8'h4F;
  localparam logic [7:0] OPC_NEGB = 8'h50;
  localparam logic [7:0] OPC_COMB = 8'h53;
  localparam logic [7:0] OPC_DECB = 8'h5A;
  localparam logic [7:0] OPC_INCB = 8'h5C;
  localparam logic [7:0] OPC_CLRB = 8'h5F;
  localparam logic [7:0] OPC_NOP  = 8'h12;

  localparam logic [15:0] PROG_BASE = 16'h1000;
  localparam int          N_RANDOM  = 200;

  logic        clk;
  logic        reset_b;
  logic        halt_b;
  logic [7:0]  data_in;
  logic [15:0] addr;
  logic [7:0]  acc_a;
  logic [7:0]  acc_b;
  logic [7:0]  cc;

  logic [7:0]  mem [0:65535];
  logic [15:0] prog_ptr;
  logic [15:0] prog_end;

  // Reference model state
  logic [1:0]  phase;
  logic [15:0] exp_addr;
  logic        pend;
  logic [7:0]  pend_op;
  logic [7:0]  exp_a;
  logic [7:0]  exp_b;
  logic [7:0]  exp_cc;
  logic        run_q;
  logic [23:0] ref_next;

  int seed = 27;
  int err_count;
  int timeout_count;
  int halt_left;
  int wait_cnt;

  core6809 DUT (
    .clk     (clk),
    .reset_b (reset_b),
    .halt_b  (halt_b),
    .data_in (data_in),
    .addr    (addr),
    .acc_a   (acc_a),
    .acc_b   (acc_b),
    .cc      (cc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Memory answers the current address shortly after each edge
  always @(posedge clk) begin
    #1;
    data_in = mem[addr];
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Flag rules per opcode, returns {A, B, CC}
  function automatic logic [23:0] ref_exec(input logic [7:0] opc, input logic [7:0] a,
                                           input logic [7:0] b, input logic [7:0] ccv);
    logic [7:0] x;
    logic [7:0] r;
    logic       v;
    logic       c;
    logic       hit;
    x   = (opc[7:4] == 4'h5) ? b : a;
    r   = x;
    v   = 1'b0;
    c   = ccv[0];
    hit = 1'b1;
    case (opc)
      OPC_CLRA, OPC_CLRB: begin
        r = 8'h00;
        c = 1'b0;
      end
      OPC_INCA, OPC_INCB: begin
        r = x + 8'h01;
        v = (x == 8'h7F);
      end
      OPC_DECA, OPC_DECB: begin
        r = x - 8'h01;
        v = (x == 8'h80);
      end
      OPC_COMA, OPC_COMB: begin
        r = ~x;
        c = 1'b1;
      end
      OPC_NEGA, OPC_NEGB: begin
        r = 8'h00 - x;
        v = (x == 8'h80);
        c = (x != 8'h00);
      end
      // NOP and anything unlisted
      default: hit = 1'b0;
    endcase
    if (!hit) begin
      return {a, b, ccv};
    end else if (opc[7:4] == 4'h5) begin
      return {a, r, ccv[7:4], r[7], r == 8'h00, v, c};
    end else begin
      return {r, b, ccv[7:4], r[7], r == 8'h00, v, c};
    end
  endfunction

  assign run_q    = (phase == 2'd3);
  assign ref_next = ref_exec(pend_op, exp_a, exp_b, exp_cc);

  // Vector fetch, then one opcode per unhalted cycle, effect one edge later
  always @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      phase    <= 2'd0;
      exp_addr <= 16'hFFFE;
      pend     <= 1'b0;
      pend_op  <= 8'h00;
      exp_a    <= 8'h00;
      exp_b    <= 8'h00;
      exp_cc   <= 8'hFF;
    end else begin
      if (pend) begin
        exp_a  <= ref_next[23:16];
        exp_b  <= ref_next[15:8];
        exp_cc <= ref_next[7:0];
      end
      case (phase)
        2'd0: phase <= 2'd1;
        2'd1: begin
          phase    <= 2'd2;
          exp_addr <= 16'hFFFF;
        end
        2'd2: begin
          phase    <= 2'd3;
          exp_addr <= {mem[16'hFFFE], mem[16'hFFFF]};
        end
        default: begin
          pend <= halt_b;
          if (halt_b) begin
            pend_op  <= mem[exp_addr];
            exp_addr <= exp_addr + 16'd1;
          end
        end
      endcase
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  task automatic note_mismatch(input string name, input logic [15:0] got,
                               input logic [15:0] want);
    err_count++;
    $display("FAIL %s: got %h, expected %h at %0t", name, got, want, $time);
  endtask

  task automatic note_failure(input string what);
    err_count++;
    $display("Error: %s at %0t", what, $time);
  endtask

  a_addr: assert property (@(posedge clk) disable iff (!reset_b) addr == exp_addr)
    else note_mismatch("addr", $sampled(addr), $sampled(exp_addr));
  a_vec_start: assert property (@(posedge clk) disable iff (!reset_b)
    $rose(run_q) |-> addr == PROG_BASE)
    else note_mismatch("addr", $sampled(addr), PROG_BASE);
  a_acc_a: assert property (@(posedge clk) disable iff (!reset_b) acc_a == exp_a)
    else note_mismatch("acc_a", $sampled(acc_a), $sampled(exp_a));
  a_acc_b: assert property (@(posedge clk) disable iff (!reset_b) acc_b == exp_b)
    else note_mismatch("acc_b", $sampled(acc_b), $sampled(exp_b));
  a_cc: assert property (@(posedge clk) disable iff (!reset_b) cc == exp_cc)
    else note_mismatch("cc", $sampled(cc), $sampled(exp_cc));
  // E, F, H and I never move
  a_cc_mask: assert property (@(posedge clk) disable iff (!reset_b) cc[7:4] == 4'hF)
    else note_mismatch("cc", $sampled(cc), {8'h00, 4'hF, $sampled(cc[3:0])});
  a_addr_step: assert property (@(posedge clk) disable iff (!reset_b)
    (run_q && halt_b) |=> addr == $past(addr) + 16'd1)
    else note_failure("addr did not advance by one while running");
  a_halt_addr: assert property (@(posedge clk) disable iff (!reset_b)
    (run_q && !halt_b) |=> $stable(addr))
    else note_failure("addr moved while halt_b was low");
  // In-flight instruction lands first, then everything holds
  a_halt_regs: assert property (@(posedge clk) disable iff (!reset_b)
    (run_q && !halt_b) |=> ##1 $stable({acc_a, acc_b, cc}))
    else note_failure("accumulators or cc changed during halt");

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  task automatic put_op(input logic [7:0] opc);
    mem[prog_ptr] = opc;
    prog_ptr      = prog_ptr + 16'd1;
  endtask

  task automatic load_program();
    logic [7:0] pool [0:15];
    pool = '{OPC_NEGA, OPC_COMA, OPC_DECA, OPC_INCA, OPC_CLRA, OPC_NEGB, OPC_COMB,
             OPC_DECB, OPC_INCB, OPC_CLRB, OPC_NOP, 8'h01, 8'h4D, 8'h5D, 8'h3A, 8'h86};
    // Background pattern from the whole address
    for (int i = 0; i < 65536; i++) begin
      mem[i] = i[7:0] ^ i[15:8] ^ 8'h3C;
    end
    mem[16'hFFFE] = PROG_BASE[15:8];
    mem[16'hFFFF] = PROG_BASE[7:0];
    prog_ptr = PROG_BASE;
    // Zero operand cases on A
    put_op(OPC_CLRA);
    put_op(OPC_NEGA);
    put_op(OPC_DECA);
    put_op(OPC_INCA);
    put_op(OPC_COMA);
    put_op(OPC_NEGA);
    // Count A up through 7F into 80
    put_op(OPC_CLRA);
    repeat (128) put_op(OPC_INCA);
    put_op(OPC_DECA);
    put_op(OPC_INCA);
    put_op(OPC_NEGA);
    put_op(OPC_COMA);
    // B down from 0 to 80, then across the boundary
    put_op(OPC_CLRB);
    put_op(OPC_NEGB);
    put_op(OPC_COMB);
    put_op(OPC_CLRB);
    repeat (128) put_op(OPC_DECB);
    put_op(OPC_NEGB);
    put_op(OPC_DECB);
    put_op(OPC_INCB);
    put_op(OPC_NOP);
    put_op(8'h01);
    put_op(8'h4D);
    repeat (N_RANDOM) put_op(pool[$unsigned($random(seed)) % 16]);
    prog_end = prog_ptr;
  endtask

  // Random halt bursts of 1 to 5 cycles
  task automatic drive_halt();
    if (halt_left > 0) begin
      halt_b    = 1'b0;
      halt_left = halt_left - 1;
    end else if (($random(seed) & 7) == 0) begin
      halt_b    = 1'b0;
      halt_left = $unsigned($random(seed)) % 5;
    end else begin
      halt_b = 1'b1;
    end
  endtask

  task automatic run_program();
    wait_cnt = 0;
    while (exp_addr != prog_end + 16'd2 && wait_cnt < 4000) begin
      @(posedge clk);
      #1;
      drive_halt();
      wait_cnt++;
    end
    if (exp_addr != prog_end + 16'd2) begin
      $display("Timeout: program did not run to its end");
      timeout_count++;
    end else begin
      // Let the last instructions land
      halt_b = 1'b1;
      repeat (3) @(posedge clk);
    end
  endtask

  task automatic finish_run();
    $display("Checks complete: %0d errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  initial begin
    reset_b       = 1'b0;
    halt_b        = 1'b1;
    data_in       = 8'h00;
    err_count     = 0;
    timeout_count = 0;
    halt_left     = 0;
    load_program();
    repeat (5) @(posedge clk);
    #1;
    reset_b = 1'b1;
    // Halt low through the vector fetch has no effect
    halt_b   = 1'b0;
    wait_cnt = 0;
    while (addr !== PROG_BASE && wait_cnt < 10) begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (addr !== PROG_BASE) begin
      $display("Timeout: reset vector fetch never reached the program");
      timeout_count++;
    end else begin
      run_program();
    end
    finish_run();
  end

endmodule
